/* filelist.f */
src/wt_cache_pkg.sv
src/axi_pkg.sv
src/wr_entry_if.sv
src/apb_store_port.sv
src/store_buffer.sv
src/axi_write_channel.sv
src/wt_store_path.sv
test/tb_clk_gen.sv
test/tb_wt_store_path.sv

/* run_sim.sh */
#!/bin/sh
# builds the store path testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_wt_store_path -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

/* test/tb_wt_store_path.sv */
module tb_wt_store_path;

    localparam int                           ADDR_W       = 32;
    localparam int                           BUF_DEPTH    = 4;
    localparam logic [axi_pkg::AXI_ID_W-1:0] AXI_ID       = 4'h5;
    localparam int                           RESET_CYCLES = 16;
    localparam int                           NROWS        = 12;
    localparam int                           ROW_BUDGET   = 200;  // cycles per table row
    localparam logic [1:0]                   OP_WR        = 2'd0;
    localparam logic [1:0]                   OP_RD        = 2'd1;
    localparam logic [1:0]                   OP_DRAIN     = 2'd2;  // drain, then status read

    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [3:0]  n_err;      // SLVERR responses before the OKAY
        logic [7:0]  aw_delay;   // cycles before awready
        logic        stall;      // write must find the buffer full
        logic [3:0]  exp_count;
    } row_t;

    row_t        rows [NROWS];
    row_t        sb [$];         // posted writes not yet acked OKAY
    logic        clk;
    logic        reset;
    logic        psel, penable, pwrite, pready;
    logic [31:0] paddr, pwdata, prdata;
    logic [3:0]  pstrb;
    logic        axi_awvalid, axi_awready, axi_awlock, axi_wvalid, axi_wready, axi_wlast;
    logic        axi_bvalid, axi_bready;
    logic [31:0] axi_awaddr;
    logic [7:0]  axi_awlen;
    logic [2:0]  axi_awsize, axi_awprot;
    logic [1:0]  axi_awburst, axi_bresp;
    logic [3:0]  axi_awcache, axi_awqos, axi_awid;
    logic [63:0] axi_wdata;
    logic [7:0]  axi_wstrb;
    int          value_errors = 0;
    int          flow_errors  = 0;
    integer      seed         = 61;

    tb_clk_gen #(.PERIOD(4), .RESET_CYCLES(RESET_CYCLES)) tb_clk_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    wt_store_path #(
        .ADDR_W    (ADDR_W),
        .BUF_DEPTH (BUF_DEPTH),
        .AXI_ID    (AXI_ID)
    ) wt_store_path_inst (.*);

    task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
        value_errors++;
        $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic flow_error(input string what);
        flow_errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // one APB transfer for table row r
    task automatic apb_access(input int r, output logic [31:0] rdata, output int waits);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = (rows[r].op == OP_WR);
        paddr  = rows[r].addr;
        pwdata = rows[r].data;
        pstrb  = rows[r].strb;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        #1;
        while (!pready) begin
            @(negedge clk);
            #1;
            waits++;
        end
        rdata = prdata;
        if (pwrite) begin
            sb.push_back(rows[r]);  // taken on the coming edge
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_drained;
        while (sb.size() != 0 || axi_bvalid || axi_bready) begin
            @(negedge clk);
            #1;
        end
    endtask

    // address, data and response phase of one beat for the scoreboard head
    task automatic serve_beat(input row_t exp, input logic err);
        logic [31:0]            e_addr;
        logic [7:0]             e_strb;
        wt_cache_pkg::be_word_u e_data;
        e_addr         = {exp.addr[31:3], 3'b000};
        e_strb         = exp.addr[2] ? {exp.strb, 4'h0} : {4'h0, exp.strb};
        e_data.lane[0] = exp.data;
        e_data.lane[1] = exp.data;
        repeat (exp.aw_delay) @(negedge clk);
        if (!axi_awvalid) flow_error("awvalid dropped before the address handshake");
        axi_awready = 1'b1;
        if (axi_awaddr !== e_addr) value_error("axi_awaddr", 64'(axi_awaddr), 64'(e_addr));
        if (axi_awlen !== 8'd0) value_error("axi_awlen", 64'(axi_awlen), 64'd0);
        if (axi_awsize !== axi_pkg::SIZE_8B)
            value_error("axi_awsize", 64'(axi_awsize), 64'(axi_pkg::SIZE_8B));
        if (axi_awburst !== axi_pkg::BURST_FIXED)
            value_error("axi_awburst", 64'(axi_awburst), 64'(axi_pkg::BURST_FIXED));
        if (axi_awcache !== axi_pkg::CACHE_ATTR)
            value_error("axi_awcache", 64'(axi_awcache), 64'(axi_pkg::CACHE_ATTR));
        if (axi_awlock !== 1'b0) value_error("axi_awlock", 64'(axi_awlock), 64'd0);
        if (axi_awprot !== 3'd0) value_error("axi_awprot", 64'(axi_awprot), 64'd0);
        if (axi_awqos !== 4'd0) value_error("axi_awqos", 64'(axi_awqos), 64'd0);
        if (axi_awid !== AXI_ID) value_error("axi_awid", 64'(axi_awid), 64'(AXI_ID));
        @(negedge clk);
        axi_awready = 1'b0;
        repeat ($unsigned($random(seed)) % 3) @(negedge clk);
        if (!axi_wvalid) flow_error("wvalid not raised after the address handshake");
        axi_wready = 1'b1;
        if (axi_wdata !== e_data.word) value_error("axi_wdata", axi_wdata, e_data.word);
        if (axi_wstrb !== e_strb) value_error("axi_wstrb", 64'(axi_wstrb), 64'(e_strb));
        if (axi_wlast !== 1'b1) value_error("axi_wlast", 64'(axi_wlast), 64'd1);
        @(negedge clk);
        axi_wready = 1'b0;
        repeat ($unsigned($random(seed)) % 3) @(negedge clk);
        if (!axi_bready) flow_error("bready not raised after the data handshake");
        axi_bvalid = 1'b1;
        axi_bresp  = err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
        @(negedge clk);
        axi_bvalid = 1'b0;
        axi_bresp  = axi_pkg::RESP_OKAY;
    endtask

    initial begin : axi_responder
        int   beats;  // error beats already sent for the head
        logic err;
        axi_awready = 1'b0;
        axi_wready  = 1'b0;
        axi_bvalid  = 1'b0;
        axi_bresp   = axi_pkg::RESP_OKAY;
        beats       = 0;
        @(negedge reset);
        forever begin
            @(negedge clk);
            if (axi_awvalid && sb.size() == 0) begin
                flow_error("AXI write issued with no write pending");
            end else if (axi_awvalid) begin
                err = (beats < int'(sb[0].n_err));
                serve_beat(sb[0], err);
                if (err) begin
                    beats++;  // same entry goes out again
                end else begin
                    void'(sb.pop_front());
                    beats = 0;
                end
            end
        end
    end

    initial begin : run_table
        logic [31:0] rdata;
        int          waits;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = '0;
        rows[0]  = '{OP_WR,    32'h1000_0000, 32'h1122_3344, 4'hf, 4'd0, 8'd0,  1'b0, 4'd0};
        rows[1]  = '{OP_WR,    32'h1000_0004, 32'ha5a5_0001, 4'h3, 4'd0, 8'd1,  1'b0, 4'd0};
        rows[2]  = '{OP_WR,    32'h2000_000c, 32'hdead_beef, 4'hf, 4'd2, 8'd0,  1'b0, 4'd0};
        rows[3]  = '{OP_DRAIN, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'd0, 8'd0,  1'b0, 4'd0};
        rows[4]  = '{OP_WR,    32'h3000_0010, 32'h0bad_f00d, 4'hc, 4'd0, 8'd60, 1'b0, 4'd0};
        rows[5]  = '{OP_WR,    32'h3000_0014, 32'h5555_aaaa, 4'h1, 4'd0, 8'd0,  1'b0, 4'd0};
        rows[6]  = '{OP_WR,    32'h3000_0018, 32'h0123_4567, 4'hf, 4'd1, 8'd0,  1'b0, 4'd0};
        rows[7]  = '{OP_WR,    32'h3000_001c, 32'h89ab_cdef, 4'h8, 4'd0, 8'd0,  1'b0, 4'd0};
        rows[8]  = '{OP_RD,    32'h0000_0040, 32'h0000_0000, 4'h0, 4'd0, 8'd0,  1'b0, 4'd4};
        rows[9]  = '{OP_WR,    32'h4000_0020, 32'hcafe_0009, 4'hf, 4'd0, 8'd0,  1'b1, 4'd0};
        rows[10] = '{OP_WR,    32'h4000_0024, 32'hcafe_000a, 4'h6, 4'd0, 8'd0,  1'b0, 4'd0};
        rows[11] = '{OP_DRAIN, 32'h0000_0080, 32'h0000_0000, 4'h0, 4'd0, 8'd0,  1'b0, 4'd0};
        @(negedge reset);
        @(negedge clk);
        #1;
        if (axi_awvalid !== 1'b0) value_error("axi_awvalid", 64'(axi_awvalid), 64'd0);
        if (axi_wvalid !== 1'b0) value_error("axi_wvalid", 64'(axi_wvalid), 64'd0);
        if (axi_bready !== 1'b0) value_error("axi_bready", 64'(axi_bready), 64'd0);
        if (pready !== 1'b1) value_error("pready", 64'(pready), 64'd1);
        for (int r = 0; r < NROWS; r++) begin
            if (rows[r].op == OP_DRAIN) begin
                wait_drained();
            end
            apb_access(r, rdata, waits);
            if (rows[r].op != OP_WR && rdata !== 32'(rows[r].exp_count)) begin
                value_error("prdata", 64'(rdata), 64'(rows[r].exp_count));
            end
            if (rows[r].stall && waits == 0) begin
                flow_error("write was accepted although the buffer was full");
            end
        end
        wait_drained();
        $display("errors: %0d value, %0d flow", value_errors, flow_errors);
        if (value_errors == 0 && flow_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + NROWS * ROW_BUDGET) @(posedge clk);
        $display("timeout: the table did not finish in %0d cycles", NROWS * ROW_BUDGET);
        $display("errors: %0d value, %0d flow", value_errors, flow_errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* test/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* src/wt_store_path.sv */
module wt_store_path #(
    parameter int                           ADDR_W    = 32,
    parameter int                           BUF_DEPTH = 4,
    parameter logic [axi_pkg::AXI_ID_W-1:0] AXI_ID    = '0
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [ADDR_W-1:0]                  paddr,
    input  logic [wt_cache_pkg::DATA_W-1:0]    pwdata,
    input  logic [wt_cache_pkg::NBYTES-1:0]    pstrb,
    output logic                               pready,
    output logic [wt_cache_pkg::DATA_W-1:0]    prdata,
    output logic                               axi_awvalid,
    output logic [ADDR_W-1:0]                  axi_awaddr,
    output logic [7:0]                         axi_awlen,
    output logic [2:0]                         axi_awsize,
    output logic [1:0]                         axi_awburst,
    output logic                               axi_awlock,
    output logic [3:0]                         axi_awcache,
    output logic [2:0]                         axi_awprot,
    output logic [3:0]                         axi_awqos,
    output logic [axi_pkg::AXI_ID_W-1:0]       axi_awid,
    input  logic                               axi_awready,
    output logic                               axi_wvalid,
    output logic [wt_cache_pkg::BE_DATA_W-1:0] axi_wdata,
    output logic [wt_cache_pkg::BE_NBYTES-1:0] axi_wstrb,
    output logic                               axi_wlast,
    input  logic                               axi_wready,
    input  logic                               axi_bvalid,
    input  logic [1:0]                         axi_bresp,
    output logic                               axi_bready
);

    logic [$clog2(BUF_DEPTH):0] pending;  // entries not yet acked

    wr_entry_if #(.ADDR_W(ADDR_W)) push_bus ();
    wr_entry_if #(.ADDR_W(ADDR_W)) head_bus ();

    apb_store_port #(
        .ADDR_W    (ADDR_W),
        .BUF_DEPTH (BUF_DEPTH)
    ) apb_store_port_inst (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (pready),
        .prdata  (prdata),
        .push    (push_bus),
        .count   (pending)
    );

    store_buffer #(
        .ADDR_W    (ADDR_W),
        .BUF_DEPTH (BUF_DEPTH)
    ) store_buffer_inst (
        .clk   (clk),
        .reset (reset),
        .push  (push_bus),
        .head  (head_bus),
        .count (pending)
    );

    axi_write_channel #(
        .ADDR_W (ADDR_W),
        .AXI_ID (AXI_ID)
    ) axi_write_channel_inst (
        .clk         (clk),
        .reset       (reset),
        .head        (head_bus),
        .axi_awvalid (axi_awvalid),
        .axi_awaddr  (axi_awaddr),
        .axi_awlen   (axi_awlen),
        .axi_awsize  (axi_awsize),
        .axi_awburst (axi_awburst),
        .axi_awlock  (axi_awlock),
        .axi_awcache (axi_awcache),
        .axi_awprot  (axi_awprot),
        .axi_awqos   (axi_awqos),
        .axi_awid    (axi_awid),
        .axi_awready (axi_awready),
        .axi_wvalid  (axi_wvalid),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_wlast   (axi_wlast),
        .axi_wready  (axi_wready),
        .axi_bvalid  (axi_bvalid),
        .axi_bresp   (axi_bresp),
        .axi_bready  (axi_bready)
    );

endmodule

/* src/axi_write_channel.sv */
module axi_write_channel #(
    parameter int                           ADDR_W = 32,
    parameter logic [axi_pkg::AXI_ID_W-1:0] AXI_ID = '0
) (
    input  logic                               clk,
    input  logic                               reset,
    wr_entry_if.sink                           head,
    output logic                               axi_awvalid,
    output logic [ADDR_W-1:0]                  axi_awaddr,
    output logic [7:0]                         axi_awlen,
    output logic [2:0]                         axi_awsize,
    output logic [1:0]                         axi_awburst,
    output logic                               axi_awlock,
    output logic [3:0]                         axi_awcache,
    output logic [2:0]                         axi_awprot,
    output logic [3:0]                         axi_awqos,
    output logic [axi_pkg::AXI_ID_W-1:0]       axi_awid,
    input  logic                               axi_awready,
    output logic                               axi_wvalid,
    output logic [wt_cache_pkg::BE_DATA_W-1:0] axi_wdata,
    output logic [wt_cache_pkg::BE_NBYTES-1:0] axi_wstrb,
    output logic                               axi_wlast,
    input  logic                               axi_wready,
    input  logic                               axi_bvalid,
    input  logic [1:0]                         axi_bresp,
    output logic                               axi_bready
);

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_ADDR   = 2'd1;
    localparam logic [1:0] S_WRITE  = 2'd2;
    localparam logic [1:0] S_VERIFY = 2'd3;

    logic [1:0]                       state;
    logic                             resp_ok;
    logic [wt_cache_pkg::LANE_W-1:0]  lane;
    wt_cache_pkg::be_word_u           be_wdata;

    assign resp_ok = axi_bvalid && (axi_bresp == axi_pkg::RESP_OKAY);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (head.valid) begin
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (!head.valid) begin
                        state <= S_IDLE;  // last ack drained the queue
                    end else if (axi_awready) begin
                        state <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (axi_wready) begin
                        state <= S_VERIFY;
                    end
                end
                default: begin
                    // okay moves to the next head, an error resends this one
                    if (axi_bvalid) begin
                        state <= S_ADDR;
                    end
                end
            endcase
        end
    end

    assign axi_awvalid = (state == S_ADDR) && head.valid;
    assign axi_wvalid  = (state == S_WRITE);
    assign axi_bready  = (state == S_VERIFY);
    assign head.ready  = (state == S_VERIFY) && resp_ok;  // entry written

    // single fixed beat per entry
    assign axi_awlen   = 8'd0;
    assign axi_awsize  = axi_pkg::SIZE_8B;
    assign axi_awburst = axi_pkg::BURST_FIXED;
    assign axi_awlock  = 1'b0;
    assign axi_awcache = axi_pkg::CACHE_ATTR;
    assign axi_awprot  = 3'd0;
    assign axi_awqos   = 4'd0;
    assign axi_awid    = AXI_ID;
    assign axi_wlast   = axi_wvalid;

    // backend word address
    assign axi_awaddr = {head.addr[ADDR_W-1:wt_cache_pkg::BE_NBYTES_W],
                         {wt_cache_pkg::BE_NBYTES_W{1'b0}}};

    // which cache word inside the backend word
    assign lane = head.addr[wt_cache_pkg::NBYTES_W +: wt_cache_pkg::LANE_W];

    // word copied to every lane, strobe picks the real one
    always_comb begin
        for (int i = 0; i < wt_cache_pkg::LANES; i++) begin
            be_wdata.lane[i] = head.wdata;
        end
    end

    assign axi_wdata = be_wdata.word;
    assign axi_wstrb = wt_cache_pkg::lane_strb(head.wstrb, lane);

    // address phase holds until accepted
    a_aw_hold: assert property (
        @(posedge clk) disable iff (reset)
        (axi_awvalid && !axi_awready) |=> (axi_awvalid && $stable(axi_awaddr))
    );

endmodule

/* src/store_buffer.sv */
module store_buffer #(
    parameter int ADDR_W    = 32,
    parameter int BUF_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    wr_entry_if.sink                   push,
    wr_entry_if.source                 head,
    output logic [$clog2(BUF_DEPTH):0] count
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH) + 1;

    logic [ADDR_W-1:0]               addr_mem [BUF_DEPTH];
    logic [wt_cache_pkg::DATA_W-1:0] data_mem [BUF_DEPTH];
    logic [wt_cache_pkg::NBYTES-1:0] strb_mem [BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full = (count == CNT_W'(BUF_DEPTH));

    // a full buffer still takes a push when the head leaves in the same cycle
    assign push.ready = !full || head.ready;
    assign do_push    = push.valid && push.ready;
    assign do_pop     = head.valid && head.ready;

    // oldest entry
    assign head.valid = (count != '0);
    assign head.addr  = addr_mem[rd_ptr];
    assign head.wdata = data_mem[rd_ptr];
    assign head.wstrb = strb_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_mem[wr_ptr] <= push.addr;
            data_mem[wr_ptr] <= push.wdata;
            strb_mem[wr_ptr] <= push.wstrb;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push with pop
            endcase
        end
    end

    // occupancy never runs past the depth
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset)
        count <= CNT_W'(BUF_DEPTH)
    );

    // the channel only acknowledges an entry that exists
    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset)
        head.ready |-> head.valid
    );

endmodule

/* src/apb_store_port.sv */
module apb_store_port #(
    parameter int ADDR_W    = 32,
    parameter int BUF_DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [ADDR_W-1:0]               paddr,
    input  logic [wt_cache_pkg::DATA_W-1:0] pwdata,
    input  logic [wt_cache_pkg::NBYTES-1:0] pstrb,
    output logic                            pready,
    output logic [wt_cache_pkg::DATA_W-1:0] prdata,
    wr_entry_if.source                      push,
    input  logic [$clog2(BUF_DEPTH):0]      count
);

    logic access;

    assign access = psel && penable;  // APB access phase

    // a write access is offered to the queue until it is taken
    assign push.valid = access && pwrite;
    assign push.addr  = paddr;
    assign push.wdata = pwdata;
    assign push.wstrb = pstrb;

    // writes wait for a free slot, reads complete at once
    assign pready = !pwrite || push.ready;

    // any read address returns the pending count
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            prdata[$clog2(BUF_DEPTH):0] = count;  // zero-extended
        end
    end

    // a stalled master must keep its request steady
    a_apb_hold: assert property (
        @(posedge clk) disable iff (reset)
        (psel && !pready) |=> ($stable(paddr) && $stable(pwdata) && $stable(pwrite))
    );

endmodule

/* src/wr_entry_if.sv */
interface wr_entry_if #(
    parameter int ADDR_W = 32
);

    logic                            valid;
    logic                            ready;  // entry taken when both high at clk edge
    logic [ADDR_W-1:0]               addr;   // byte address of the cache word
    logic [wt_cache_pkg::DATA_W-1:0] wdata;
    logic [wt_cache_pkg::NBYTES-1:0] wstrb;

    // side that offers the entry
    modport source (
        output valid,
        output addr,
        output wdata,
        output wstrb,
        input  ready
    );

    // side that accepts the entry
    modport sink (
        input  valid,
        input  addr,
        input  wdata,
        input  wstrb,
        output ready
    );

endinterface

/* src/axi_pkg.sv */
package axi_pkg;

    localparam int AXI_ID_W = 4;

    // burst types
    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;

    // write response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_EXOKAY = 2'b01;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // beat size, log2 of the byte count
    localparam logic [2:0] SIZE_8B = 3'b011;

    // modifiable and bufferable
    localparam logic [3:0] CACHE_ATTR = 4'b0011;

endpackage

/* src/wt_cache_pkg.sv */
package wt_cache_pkg;

    localparam int DATA_W      = 32;                // cache word
    localparam int NBYTES      = DATA_W / 8;
    localparam int NBYTES_W    = $clog2(NBYTES);
    localparam int BE_DATA_W   = 64;                // backend memory word
    localparam int BE_NBYTES   = BE_DATA_W / 8;
    localparam int BE_NBYTES_W = $clog2(BE_NBYTES);
    localparam int LANES       = BE_DATA_W / DATA_W; // cache words per backend word
    localparam int LANE_W      = $clog2(LANES);

    // one backend beat, seen whole or as cache-word lanes
    typedef union packed {
        logic [BE_DATA_W-1:0]         word;
        logic [LANES-1:0][DATA_W-1:0] lane;
    } be_word_u;

    // moves a cache-word strobe onto its lane of the backend word
    function automatic logic [BE_NBYTES-1:0] lane_strb(
        input logic [NBYTES-1:0] strb,
        input logic [LANE_W-1:0] lane
    );
        logic [BE_NBYTES-1:0] wide;
        wide             = '0;
        wide[NBYTES-1:0] = strb;
        return wide << (lane * NBYTES);
    endfunction

endpackage
